/* hw/gomoku_consts.svh */
`ifndef GOMOKU_CONSTS_SVH
`define GOMOKU_CONSTS_SVH

// board geometry
`define BOARD_DIM 16
`define COORD_W   4   // bits per row or column index
`define WIN_LEN   5   // stones in a line that end the game

// register byte offsets
`define REG_MOVE     5'h00
`define REG_CTRL     5'h04
`define REG_CELL_SEL 5'h08
`define REG_STATUS   5'h0C
`define REG_CELL     5'h10

// axi4-lite bus widths
`define AXI_AW 5
`define AXI_DW 32

`endif

/* hw/gomoku_pkg.sv */
`include "gomoku_consts.svh"

package gomoku_pkg;

    // two bits per board point
    typedef enum logic [1:0] {
        EMPTY = 2'b00,
        BLACK = 2'b01,  // player0
        WHITE = 2'b10   // player1
    } cell_t;

    // one write word with two readings
    typedef union packed {
        struct packed {
            logic [`AXI_DW-2*`COORD_W-1:0] rsvd;
            logic [`COORD_W-1:0]           row;  // high nibble of the low byte
            logic [`COORD_W-1:0]           col;
        } move;                                    // MOVE and CELL_SEL
        struct packed {
            logic [`AXI_DW-3:0] rsvd;
            logic               new_game;
            logic               pass;
        } ctrl;                                    // CTRL
    } reg_word_u;

    typedef struct packed {
        logic [16:0] rsvd;
        logic [8:0]  move_count;  // stones placed this game
        logic        last_ok;     // last move went onto the board
        cell_t       winner;
        cell_t       turn;
        logic        busy;        // move in flight
    } status_t;

endpackage

/* hw/gomoku_regs.sv */
`timescale 1ns/100ps
`include "gomoku_consts.svh"

module gomoku_regs (
    input  logic                      clock,
    input  logic                      rst,
    input  logic [`AXI_AW-1:0]        awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [`AXI_DW-1:0]        wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output logic                      bvalid,
    output logic [1:0]                bresp,
    input  logic                      bready,
    input  logic [`AXI_AW-1:0]        araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic                      rvalid,
    output logic [`AXI_DW-1:0]        rdata,
    output logic [1:0]                rresp,
    input  logic                      rready,
    input  logic                      placed,      // stone went down
    input  logic                      refused,     // stone rejected
    input  logic                      done,        // checker finished
    input  logic                      win,
    input  gomoku_pkg::cell_t         cell_state,  // point picked by CELL_SEL
    output logic                      move_req,
    output logic [`COORD_W-1:0]       move_row,
    output logic [`COORD_W-1:0]       move_col,
    output logic                      new_game,
    output gomoku_pkg::cell_t         turn,
    output gomoku_pkg::cell_t         winner,
    output logic                      busy,
    output logic [`COORD_W-1:0]       cell_row,
    output logic [`COORD_W-1:0]       cell_col
);

    gomoku_pkg::reg_word_u wv;
    gomoku_pkg::status_t   status;
    gomoku_pkg::cell_t     other;
    logic                  wr_fire;
    logic                  ar_fire;
    logic                  pass_req;
    logic                  last_ok;
    logic [8:0]            move_count;
    logic [`COORD_W-1:0]   last_row;
    logic [`COORD_W-1:0]   last_col;

    assign wv = wdata;

    // aw and w are taken together, none while a move is still resolving
    assign awready = awvalid && wvalid && !bvalid && !busy;
    assign wready  = awready;
    assign wr_fire = awready;
    assign bresp   = 2'b00;  // always OKAY
    assign arready = arvalid && !rvalid;
    assign ar_fire = arready;
    assign rresp   = 2'b00;

    // strobes leave in the handshake cycle so placed lands one cycle later
    assign move_req = wr_fire && awaddr == `REG_MOVE;
    assign new_game = wr_fire && awaddr == `REG_CTRL && wv.ctrl.new_game;
    assign pass_req = wr_fire && awaddr == `REG_CTRL && wv.ctrl.pass && !wv.ctrl.new_game;

    // coordinates follow the bus during the request, then hold for the display
    assign move_row = move_req ? wv.move.row : last_row;
    assign move_col = move_req ? wv.move.col : last_col;

    assign other = (turn == gomoku_pkg::BLACK) ? gomoku_pkg::WHITE : gomoku_pkg::BLACK;

    always_ff @(posedge clock) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            last_row <= '0;
            last_col <= '0;
            cell_row <= '0;
            cell_col <= '0;
        end else begin
            if (move_req) begin
                last_row <= wv.move.row;
                last_col <= wv.move.col;
            end
            if (wr_fire && awaddr == `REG_CELL_SEL) begin  // read-back pointer
                cell_row <= wv.move.row;
                cell_col <= wv.move.col;
            end
        end
    end

    // game state, a new game behaves like reset here
    always_ff @(posedge clock) begin
        if (rst || new_game) begin
            turn       <= gomoku_pkg::BLACK;
            winner     <= gomoku_pkg::EMPTY;
            last_ok    <= 1'b0;
            move_count <= '0;
            busy       <= 1'b0;
        end else begin
            if (move_req) begin
                busy <= 1'b1;
            end else if (refused || done) begin
                busy <= 1'b0;  // refused ends the move at once
            end
            if (placed) begin
                last_ok    <= 1'b1;
                move_count <= move_count + 9'd1;
            end
            if (refused) begin
                last_ok <= 1'b0;
            end
            if (done) begin
                if (win) begin
                    winner <= turn;  // turn still names the mover
                end else begin
                    turn <= other;
                end
            end
            if (pass_req && winner == gomoku_pkg::EMPTY) begin
                turn <= other;
            end
        end
    end

    always_comb begin
        status            = '0;
        status.busy       = busy;
        status.turn       = turn;
        status.winner     = winner;
        status.last_ok    = last_ok;
        status.move_count = move_count;
    end

    always_ff @(posedge clock) begin
        if (ar_fire) begin
            case (araddr)
                `REG_MOVE:     rdata <= {{(`AXI_DW-2*`COORD_W){1'b0}}, last_row, last_col};
                `REG_CELL_SEL: rdata <= {{(`AXI_DW-2*`COORD_W){1'b0}}, cell_row, cell_col};
                `REG_STATUS:   rdata <= status;
                `REG_CELL:     rdata <= {{(`AXI_DW-2){1'b0}}, cell_state};
                default:       rdata <= '0;  // CTRL and holes
            endcase
        end
    end

    // response stays up until the master takes it
    a_bvalid_hold: assert property (@(posedge clock) disable iff (rst)
        bvalid && !bready |=> bvalid);

    // datapath answers only arrive inside a move, while the bus is held off
    a_no_aw_busy: assert property (@(posedge clock) disable iff (rst)
        (placed || refused || done) |-> busy && !awready);

endmodule

/* hw/board_store.sv */
`timescale 1ns/100ps
`include "gomoku_consts.svh"

module board_store (
    input  logic                clock,
    input  logic                rst,
    input  logic                new_game,   // wipe every point
    input  logic                move_req,
    input  logic [`COORD_W-1:0] move_row,
    input  logic [`COORD_W-1:0] move_col,
    input  gomoku_pkg::cell_t   color,      // stone of the player to move
    input  logic                blocked,    // game won or checker running
    input  logic [`COORD_W-1:0] probe_row,
    input  logic [`COORD_W-1:0] probe_col,
    input  logic [`COORD_W-1:0] cell_row,
    input  logic [`COORD_W-1:0] cell_col,
    output logic                placed,
    output logic                refused,
    output gomoku_pkg::cell_t   probe_cell,
    output gomoku_pkg::cell_t   cell_state
);

    logic [2*`BOARD_DIM*`BOARD_DIM-1:0] board;  // row-major, 2 bits a point
    gomoku_pkg::cell_t                  move_cell;

    // {row, col, 0} is the bit offset of a point
    assign move_cell  = gomoku_pkg::cell_t'(board[{move_row, move_col, 1'b0} +: 2]);
    assign probe_cell = gomoku_pkg::cell_t'(board[{probe_row, probe_col, 1'b0} +: 2]);
    assign cell_state = gomoku_pkg::cell_t'(board[{cell_row, cell_col, 1'b0} +: 2]);

    always_ff @(posedge clock) begin
        if (rst || new_game) begin
            board   <= '0;
            placed  <= 1'b0;
            refused <= 1'b0;
        end else begin
            placed  <= 1'b0;  // both are single-cycle
            refused <= 1'b0;
            if (move_req) begin
                if (move_cell == gomoku_pkg::EMPTY && !blocked) begin
                    board[{move_row, move_col, 1'b0} +: 2] <= color;
                    placed <= 1'b1;
                end else begin
                    refused <= 1'b1;  // occupied, won or busy
                end
            end
        end
    end

    // the point was free before and holds the mover's stone after
    a_place_empty: assert property (@(posedge clock) disable iff (rst)
        placed |-> $past(move_cell) == gomoku_pkg::EMPTY && move_cell == $past(color));

endmodule

/* hw/win_checker.sv */
`timescale 1ns/100ps
`include "gomoku_consts.svh"

module win_checker (
    input  logic                clock,
    input  logic                rst,
    input  logic                start,       // placed pulse
    input  logic [`COORD_W-1:0] row,         // last stone
    input  logic [`COORD_W-1:0] col,
    input  gomoku_pkg::cell_t   color,
    input  gomoku_pkg::cell_t   probe_cell,
    output logic [`COORD_W-1:0] probe_row,
    output logic [`COORD_W-1:0] probe_col,
    output logic                busy,
    output logic                done,
    output logic                win
);

    typedef enum logic [1:0] {IDLE, SCAN, FIN} state_t;

    state_t                     state;
    logic [1:0]                 dir;        // horiz, vert, diag, anti-diag
    logic                       side;       // 0 forward 1 backward
    logic [2:0]                 step;       // distance from the stone
    logic [2:0]                 count;      // matches in this direction
    logic [`COORD_W-1:0]        base_row;
    logic [`COORD_W-1:0]        base_col;
    gomoku_pkg::cell_t          me;
    logic signed [`COORD_W+1:0] off;
    logic signed [`COORD_W+1:0] pr;
    logic signed [`COORD_W+1:0] pc;
    logic                       match;
    logic                       last_step;
    logic                       five;

    always_comb begin
        off = $signed({{(`COORD_W-1){1'b0}}, step});
        if (side) begin
            off = -off;
        end
        pr = $signed({2'b00, base_row});
        pc = $signed({2'b00, base_col});
        case (dir)
            2'd0: pc = pc + off;
            2'd1: pr = pr + off;
            2'd2: begin
                pr = pr + off;
                pc = pc + off;
            end
            default: begin  // anti-diagonal runs down-left
                pr = pr + off;
                pc = pc - off;
            end
        endcase
    end

    assign probe_row = pr[`COORD_W-1:0];
    assign probe_col = pc[`COORD_W-1:0];

    // off-board probes read some other point, so bounds gate the match
    assign match = pr >= 0 && pr < `BOARD_DIM && pc >= 0 && pc < `BOARD_DIM
                   && probe_cell == me;
    assign last_step = step == 3'(`WIN_LEN - 1);
    assign five      = match && int'(count) + 2 >= `WIN_LEN;  // this one plus the stone

    assign busy = start || state != IDLE;
    assign done = state == FIN;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= IDLE;
            win   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= SCAN;
                        win   <= 1'b0;
                    end
                end
                SCAN: begin
                    if (five) begin
                        win   <= 1'b1;
                        state <= FIN;  // no need to look further
                    end else if ((!match || last_step) && side && dir == 2'd3) begin
                        state <= FIN;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // walk pointers, loaded on start
    always_ff @(posedge clock) begin
        if (start && state == IDLE) begin
            base_row <= row;
            base_col <= col;
            me       <= color;
            dir      <= 2'd0;
            side     <= 1'b0;
            step     <= 3'd1;
            count    <= 3'd0;
        end else if (state == SCAN) begin
            if (match && !last_step) begin
                count <= count + 3'd1;
                step  <= step + 3'd1;
            end else begin
                step <= 3'd1;  // this side is finished
                side <= !side;
                if (side) begin
                    dir   <= dir + 2'd1;
                    count <= 3'd0;
                end else if (match) begin
                    count <= count + 3'd1;  // carried into the backward side
                end
            end
        end
    end

    // done closes a busy window that ends on the next cycle
    a_done_busy: assert property (@(posedge clock) disable iff (rst)
        done |-> busy ##1 !busy);

endmodule

/* hw/status_display.sv */
`timescale 1ns/100ps
`include "gomoku_consts.svh"

module status_display (
    input  logic [`COORD_W-1:0] last_row,
    input  logic [`COORD_W-1:0] last_col,
    input  gomoku_pkg::cell_t   turn,
    input  gomoku_pkg::cell_t   winner,
    output logic [6:0]          hex0,  // column
    output logic [6:0]          hex1,  // row
    output logic [7:0]          ledr,
    output logic [7:0]          ledg
);

    // active-low segments, gfedcba
    function automatic logic [6:0] seg7(input logic [3:0] v);
        case (v)
            4'h0: seg7 = 7'b1000000;
            4'h1: seg7 = 7'b1111001;
            4'h2: seg7 = 7'b0100100;
            4'h3: seg7 = 7'b0110000;
            4'h4: seg7 = 7'b0011001;
            4'h5: seg7 = 7'b0010010;
            4'h6: seg7 = 7'b0000010;
            4'h7: seg7 = 7'b1111000;
            4'h8: seg7 = 7'b0000000;
            4'h9: seg7 = 7'b0010000;
            4'hA: seg7 = 7'b0001000;
            4'hB: seg7 = 7'b0000011;  // lower-case b
            4'hC: seg7 = 7'b1000110;
            4'hD: seg7 = 7'b0100001;  // lower-case d
            4'hE: seg7 = 7'b0000110;
            default: seg7 = 7'b0001110;
        endcase
    endfunction

    assign hex1 = seg7(last_row);
    assign hex0 = seg7(last_col);

    always_comb begin
        ledr = '0;
        ledg = '0;
        if (winner != gomoku_pkg::EMPTY) begin  // win lights replace turn lights
            ledr[7] = winner == gomoku_pkg::BLACK;
            ledg[0] = winner == gomoku_pkg::WHITE;
        end else begin
            ledr[0] = turn == gomoku_pkg::BLACK;
            ledg[7] = turn == gomoku_pkg::WHITE;
        end
    end

endmodule

/* hw/gomoku_top.sv */
`timescale 1ns/100ps
`include "gomoku_consts.svh"

module gomoku_top (
    input  logic               clock,
    input  logic               rst,
    input  logic [`AXI_AW-1:0] awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  logic [`AXI_DW-1:0] wdata,
    input  logic               wvalid,
    output logic               wready,
    output logic               bvalid,
    output logic [1:0]         bresp,
    input  logic               bready,
    input  logic [`AXI_AW-1:0] araddr,
    input  logic               arvalid,
    output logic               arready,
    output logic               rvalid,
    output logic [`AXI_DW-1:0] rdata,
    output logic [1:0]         rresp,
    input  logic               rready,
    output logic [6:0]         hex0,
    output logic [6:0]         hex1,
    output logic [7:0]         ledr,
    output logic [7:0]         ledg
);

    logic                move_req;
    logic                new_game;
    logic [`COORD_W-1:0] move_row;
    logic [`COORD_W-1:0] move_col;
    logic [`COORD_W-1:0] cell_row;
    logic [`COORD_W-1:0] cell_col;
    logic [`COORD_W-1:0] probe_row;
    logic [`COORD_W-1:0] probe_col;
    gomoku_pkg::cell_t   turn;
    gomoku_pkg::cell_t   winner;
    gomoku_pkg::cell_t   cell_state;
    gomoku_pkg::cell_t   probe_cell;
    logic                chk_busy;
    logic                blocked;
    logic                placed;
    logic                refused;
    logic                done;
    logic                win;

    assign blocked = winner != gomoku_pkg::EMPTY || chk_busy;  // no stones after a win

    gomoku_regs u_regs (
        .clock, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bvalid, .bresp, .bready,
        .araddr, .arvalid, .arready, .rvalid, .rdata, .rresp, .rready,
        .placed, .refused, .done, .win, .cell_state,
        .move_req, .move_row, .move_col, .new_game, .turn, .winner,
        .busy (),
        .cell_row, .cell_col
    );

    board_store u_board (
        .clock, .rst, .new_game, .move_req, .move_row, .move_col,
        .color (turn),
        .blocked, .probe_row, .probe_col, .cell_row, .cell_col,
        .placed, .refused, .probe_cell, .cell_state
    );

    win_checker u_check (
        .clock, .rst,
        .start (placed),
        .row   (move_row),  // held at the last move by now
        .col   (move_col),
        .color (turn),
        .probe_cell, .probe_row, .probe_col,
        .busy  (chk_busy),
        .done, .win
    );

    status_display u_disp (
        .last_row (move_row),
        .last_col (move_col),
        .turn, .winner, .hex0, .hex1, .ledr, .ledg
    );

endmodule

/* verif/gomoku_tb.sv */
`timescale 1ns/100ps
`include "gomoku_consts.svh"

module gomoku_tb;

    localparam int LIMIT = 50;  // cycles allowed for one bus handshake
    localparam int POLLS = 40;  // status reads allowed while a move resolves

    logic               clock;
    logic               rst;
    logic [`AXI_AW-1:0] awaddr;
    logic               awvalid;
    logic               awready;
    logic [`AXI_DW-1:0] wdata;
    logic               wvalid;
    logic               wready;
    logic               bvalid;
    logic [1:0]         bresp;
    logic               bready;
    logic [`AXI_AW-1:0] araddr;
    logic               arvalid;
    logic               arready;
    logic               rvalid;
    logic [`AXI_DW-1:0] rdata;
    logic [1:0]         rresp;
    logic               rready;
    logic [6:0]         hex0;
    logic [6:0]         hex1;
    logic [7:0]         ledr;
    logic [7:0]         ledg;

    int seed = 32'hfdcc;
    int errors;
    int checks;
    bit hung;  // some wait ran out of time

    gomoku_top UUT (.*);

    always #5 clock = ~clock;

    // aw and w together, then collect the response
    task automatic axi_write(input logic [`AXI_AW-1:0] addr, input logic [`AXI_DW-1:0] data,
                             input string name);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        @(negedge clock);
        while (!(awready && wready) && n < LIMIT) begin  // held off while a move is busy
            @(negedge clock);
            n++;
        end
        if (!(awready && wready)) begin
            $display("%0s: write address never accepted", name);
            hung = 1'b1;
        end
        @(posedge clock);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (hung) return;
        bready = 1'b1;
        n = 0;
        @(negedge clock);
        while (!bvalid && n < LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!bvalid) begin
            $display("%0s: no write response", name);
            hung = 1'b1;
        end else if (bresp != 2'b00) begin
            $display("%0s: write response was not OKAY", name);
            errors++;
        end
        @(posedge clock);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [`AXI_AW-1:0] addr, output logic [`AXI_DW-1:0] data,
                            input string name);
        int n;
        data    = '0;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        @(negedge clock);
        while (!arready && n < LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!arready) begin
            $display("%0s: read address never accepted", name);
            hung = 1'b1;
        end
        @(posedge clock);
        #1;
        arvalid = 1'b0;
        if (hung) return;
        rready = 1'b1;
        n = 0;
        @(negedge clock);
        while (!rvalid && n < LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!rvalid) begin
            $display("%0s: no read data", name);
            hung = 1'b1;
        end else if (rresp != 2'b00) begin
            $display("%0s: read response was not OKAY", name);
            errors++;
        end
        data = rdata;  // stable until the next edge
        @(posedge clock);
        #1;
        rready = 1'b0;
    endtask

    // a move is over once busy drops in STATUS
    task automatic wait_idle(input string name);
        gomoku_pkg::status_t s;
        logic [`AXI_DW-1:0]  rd;
        int                  n;
        s      = '0;
        s.busy = 1'b1;
        n      = 0;
        while (s.busy && n < POLLS && !hung) begin
            axi_read(`REG_STATUS, rd, name);
            s = rd;
            n++;
        end
        if (s.busy && !hung) begin
            $display("%0s: still busy after %0d status reads", name, POLLS);
            hung = 1'b1;
        end
    endtask

    task automatic check_cell(input string name, input gomoku_pkg::cell_t exp,
                              input gomoku_pkg::cell_t act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %0s expected %0s actual %0s", name, exp.name(), act.name());
            errors++;
        end else begin
            $display("ok %0s", name);
        end
    endtask

    task automatic check_status(input string name, input gomoku_pkg::status_t exp,
                                input gomoku_pkg::status_t act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %0s expected %h actual %h", name, exp, act);
            errors++;
        end else begin
            $display("ok %0s", name);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %0s expected %h actual %h", name, exp, act);
            errors++;
        end else begin
            $display("ok %0s", name);
        end
    endtask

    initial begin
        gomoku_pkg::reg_word_u w;
        gomoku_pkg::status_t   es;
        logic [`AXI_DW-1:0]    rd;
        logic [8*128-1:0]      line;
        string                 op;
        string                 name;
        int                    fd;
        int                    r;
        int                    t;
        int                    a;
        int                    b;
        int                    c;
        int                    d;
        clock   = 1'b0;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        errors  = 0;
        checks  = 0;
        hung    = 1'b0;
        t       = 0;
        repeat (3) @(posedge clock);
        #1;
        rst = 1'b0;
        fd = $fopen("verif/gomoku_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/gomoku_stim.txt");
            errors++;
        end else begin
            while (!hung) begin
                r = $fscanf(fd, "%s", op);
                if (r != 1) break;  // end of file
                if (op == "#") begin
                    r = $fgets(line, fd);
                    continue;
                end
                t++;
                w = '0;
                if (op == "MOVE") begin
                    r = $fscanf(fd, "%d %d", a, b);
                    name = $sformatf("%0d move %0d %0d", t, a, b);
                    w.move.row = a[3:0];
                    w.move.col = b[3:0];
                    axi_write(`REG_MOVE, w, name);
                    wait_idle(name);
                end else if (op == "PASS") begin
                    w.ctrl.pass = 1'b1;
                    axi_write(`REG_CTRL, w, $sformatf("%0d pass", t));
                end else if (op == "NEW") begin
                    w.ctrl.new_game = 1'b1;
                    axi_write(`REG_CTRL, w, $sformatf("%0d new game", t));
                end else if (op == "EXPECT_STATUS") begin
                    r = $fscanf(fd, "%d %d %d %d", a, b, c, d);
                    name = $sformatf("%0d status", t);
                    es            = '0;  // busy low, spare bits zero
                    es.turn       = gomoku_pkg::cell_t'(a[1:0]);
                    es.winner     = gomoku_pkg::cell_t'(b[1:0]);
                    es.last_ok    = c[0];
                    es.move_count = d[8:0];
                    axi_read(`REG_STATUS, rd, name);
                    if (!hung) check_status(name, es, rd);
                end else if (op == "EXPECT_CELL") begin
                    r = $fscanf(fd, "%d %d %d", a, b, c);
                    name = $sformatf("%0d cell %0d %0d", t, a, b);
                    w.move.row = a[3:0];
                    w.move.col = b[3:0];
                    axi_write(`REG_CELL_SEL, w, name);
                    if (!hung) axi_read(`REG_CELL, rd, name);
                    if (!hung) check_cell(name, gomoku_pkg::cell_t'(c[1:0]),
                                          gomoku_pkg::cell_t'(rd[1:0]));
                end else if (op == "EXPECT_LED") begin
                    r = $fscanf(fd, "%h %h", a, b);
                    @(negedge clock);
                    check_word($sformatf("%0d leds", t), {16'h0, a[7:0], b[7:0]},
                               {16'h0, ledr, ledg});
                    @(posedge clock);
                    #1;
                end else if (op == "EXPECT_HEX") begin
                    r = $fscanf(fd, "%h %h", a, b);
                    @(negedge clock);
                    check_word($sformatf("%0d hex", t), {18'h0, a[6:0], b[6:0]},
                               {18'h0, hex1, hex0});
                    @(posedge clock);
                    #1;
                end else begin
                    $display("unknown operation %0s at entry %0d of the stimulus", op, t);
                    errors++;
                    break;
                end
            end
            $fclose(fd);
        end
        $display("%0d checks, %0d errors%0s", checks, errors,
                 hung ? ", run stopped on a timeout" : "");
        if (errors == 0 && !hung) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verif/gomoku_stim.txt */
# columns: op then operands, colors 0 empty 1 black 2 white
# MOVE row col | PASS | NEW | EXPECT_STATUS turn winner last_ok count | EXPECT_CELL row col color
# EXPECT_LED ledr ledg and EXPECT_HEX hex1 hex0 take hex words
# reset state
EXPECT_STATUS 1 0 0 0
EXPECT_LED 01 00
# first stone, read back and shown on the digits
MOVE 3 4
EXPECT_CELL 3 4 1
EXPECT_STATUS 2 0 1 1
EXPECT_HEX 30 19
EXPECT_LED 00 80
# occupied point is refused
MOVE 3 4
EXPECT_STATUS 2 0 0 1
EXPECT_CELL 3 4 1
# black diagonal closed in the middle
MOVE 0 0
MOVE 5 5
MOVE 0 2
MOVE 6 6
MOVE 0 4
MOVE 8 8
MOVE 0 6
MOVE 9 9
MOVE 0 8
MOVE 7 7
EXPECT_STATUS 1 1 1 11
EXPECT_LED 80 00
MOVE 10 10
EXPECT_STATUS 1 1 0 11
EXPECT_CELL 10 10 0
# new game then a white five against the right edge
NEW
EXPECT_STATUS 1 0 0 0
EXPECT_CELL 7 7 0
MOVE 10 0
MOVE 2 15
MOVE 10 2
MOVE 2 14
MOVE 10 4
MOVE 2 13
MOVE 10 6
MOVE 2 11
MOVE 10 8
MOVE 2 12
EXPECT_STATUS 2 2 1 10
EXPECT_LED 00 01
EXPECT_CELL 2 15 2
# pass hands the turn over
NEW
EXPECT_LED 01 00
PASS
EXPECT_STATUS 2 0 0 0
EXPECT_LED 00 80
PASS
EXPECT_STATUS 1 0 0 0

/* filelist.f */
+incdir+hw
hw/gomoku_pkg.sv
hw/gomoku_regs.sv
hw/board_store.sv
hw/win_checker.sv
hw/status_display.sv
hw/gomoku_top.sv
verif/gomoku_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module gomoku_tb || exit 1
out=$(./obj_dir/Vgomoku_tb)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
